// File: Makefile
TOP = tb_lsu
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: byte_lane_ram.sv
`timescale 1ns/100ps

module byte_lane_ram import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rd_en,
  input  logic [IDX_W-1:0] rd_index,
  input  logic             wr_en,
  input  logic [IDX_W-1:0] wr_index,
  input  logic [7:0]       wr_byte,
  output logic [7:0]       rd_byte
);

  logic [7:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_byte;
    end
  end

  // registered read; a same-edge write to the same word is passed through.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (wr_en && wr_index == rd_index) begin
        rd_byte <= wr_byte;
      end else begin
        rd_byte <= mem[rd_index];
      end
    end
  end

endmodule

// File: compile.f
lsu_pkg.sv
lsu_issue.sv
byte_lane_ram.sv
mem_stage.sv
wb_stage.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

// File: lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_ack,
  input  mem_op_e           cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [XLEN-1:0]   cmd_wdata,
  input  logic              rsp_req,
  input  logic [XLEN-1:0]   rsp_data,
  input  logic              rsp_excp,
  output int                errors,
  output int                pending,
  output int                responses
);

  logic [7:0]      shadow [DEPTH][LANES];
  logic [XLEN-1:0] exp_data [$];
  logic            exp_excp [$];
  bit              rst_q;
  bit              ack_q;
  bit              req_q;

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 1;
      OP_LH, OP_LHU, OP_SH: return 2;
      OP_LW, OP_LWU, OP_SW: return 4;
      default:              return 8;
    endcase
  endfunction

  // apply one command to the shadow memory and queue its response.
  task automatic record_cmd(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [XLEN-1:0] wdata);
    int               size;
    int               off;
    logic [IDX_W-1:0] idx;
    logic [OFF_W-1:0] lane;
    logic             excp;
    logic [XLEN-1:0]  data;
    size = access_bytes(op);
    idx  = addr[ADDR_W-1:OFF_W];
    off  = int'(addr[OFF_W-1:0]);
    excp = (off % size) != 0;
    data = '0;
    for (int b = 0; b < size; b++) begin
      lane = OFF_W'(off + b);
      if (excp) begin
        // nothing moves on a fault.
      end else if (op inside {OP_SB, OP_SH, OP_SW, OP_SD}) begin
        shadow[idx][lane] = 8'(wdata >> (8 * b));
      end else begin
        data = data | (XLEN'(shadow[idx][lane]) << (8 * b));
      end
    end
    if (!excp && op inside {OP_LB, OP_LH, OP_LW} && ((data >> (8 * size - 1)) & 1) != 0) begin
      data = data | ~((XLEN'(1) << (8 * size)) - 1);
    end
    exp_data.push_back(data);
    exp_excp.push_back(excp);
  endtask

  task automatic compare_rsp();
    logic [XLEN-1:0] want_data;
    logic            want_excp;
    responses++;
    if (exp_data.size() == 0) begin
      errors++;
      $display("response %0d arrived with no command outstanding", responses);
    end else begin
      want_data = exp_data.pop_front();
      want_excp = exp_excp.pop_front();
      if (rsp_data !== want_data) begin
        errors++;
        $display("CHECK FAILED rsp_data: got 0x%h, expected 0x%h", rsp_data, want_data);
      end
      if (rsp_excp !== want_excp) begin
        errors++;
        $display("CHECK FAILED rsp_excp: got 0x%h, expected 0x%h", rsp_excp, want_excp);
      end
    end
  endtask

  // sampled mid-cycle, away from the driving edge.
  always @(negedge clk) begin
    if (rst_q && !rst) begin
      if (cmd_ack !== 1'b0) begin
        errors++;
        $display("CHECK FAILED cmd_ack after reset: got 0x%h, expected 0x0", cmd_ack);
      end
      if (rsp_req !== 1'b0) begin
        errors++;
        $display("CHECK FAILED rsp_req after reset: got 0x%h, expected 0x0", rsp_req);
      end
    end
    if (!rst && cmd_ack && !ack_q) begin
      record_cmd(cmd_op, cmd_addr, cmd_wdata);
    end
    if (!rst && rsp_req && !req_q) begin
      compare_rsp();
    end
    pending = exp_data.size();
    rst_q   = rst;
    ack_q   = cmd_ack;
    req_q   = rsp_req;
  end

endmodule

// File: lsu_issue.sv
`timescale 1ns/100ps

module lsu_issue import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_req,
  input  mem_op_e           cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [XLEN-1:0]   cmd_wdata,
  output logic              cmd_ack,
  input  logic              mem_allowin,
  output logic              ex_mem_valid,
  output mem_op_e           ex_op,
  output logic [ADDR_W-1:0] ex_addr,
  output logic [XLEN-1:0]   ex_wdata,
  output logic              rd_en,
  output logic [IDX_W-1:0]  rd_index
);

  hs_state_e state;
  logic      handoff;

  // busy means a command sits in the execute register.
  assign ex_mem_valid = (state == HS_BUSY);
  assign cmd_ack      = (state == HS_DONE);

  assign handoff  = ex_mem_valid && mem_allowin;
  assign rd_en    = handoff;
  assign rd_index = ex_addr[ADDR_W-1:OFF_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE: begin
          if (cmd_req) begin
            state <= HS_BUSY;
          end
        end
        HS_BUSY: begin
          if (handoff) begin
            state <= HS_DONE;
          end
        end
        HS_DONE: begin
          // wait for the requester to drop its req.
          if (!cmd_req) begin
            state <= HS_IDLE;
          end
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  // execute register, loaded once per command.
  always_ff @(posedge clk) begin
    if (state == HS_IDLE && cmd_req) begin
      ex_op    <= cmd_op;
      ex_addr  <= cmd_addr;
      ex_wdata <= cmd_wdata;
    end
  end

  // ack only ever follows a handoff into the memory stage.
  ack_after_handoff: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> $past(ex_mem_valid && mem_allowin));

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

  // data path and memory geometry.
  localparam int XLEN   = 64;
  localparam int LANES  = XLEN / 8;
  localparam int DEPTH  = 16;
  localparam int IDX_W  = 4;
  localparam int ADDR_W = 7;

  // byte offset inside one word.
  localparam int OFF_W  = ADDR_W - IDX_W;

  // memory opcodes, loads first.
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LD  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_LWU = 4'd6,
    OP_SB  = 4'd7,
    OP_SH  = 4'd8,
    OP_SW  = 4'd9,
    OP_SD  = 4'd10
  } mem_op_e;

  // phases of a four-phase req/ack exchange.
  typedef enum logic [1:0] {
    HS_IDLE = 2'd0,
    HS_BUSY = 2'd1,
    HS_DONE = 2'd2
  } hs_state_e;

endpackage

// File: lsu_top.sv
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_req,
  output logic              cmd_ack,
  input  mem_op_e           cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [XLEN-1:0]   cmd_wdata,
  output logic              rsp_req,
  input  logic              rsp_ack,
  output logic [XLEN-1:0]   rsp_data,
  output logic              rsp_excp
);

  logic              ex_mem_valid;
  logic              mem_allowin;
  mem_op_e           ex_op;
  logic [ADDR_W-1:0] ex_addr;
  logic [XLEN-1:0]   ex_wdata;
  logic              rd_en;
  logic [IDX_W-1:0]  rd_index;
  logic [XLEN-1:0]   mem_rd_data;
  logic [XLEN-1:0]   mem_wr_data;
  logic [LANES-1:0]  byte_enable;
  logic [IDX_W-1:0]  wr_index;
  logic              mem_wb_valid;
  logic              wb_allowin;
  logic [XLEN-1:0]   mem_data;
  logic              mem_excp;

  lsu_issue u_issue (
    .clk          (clk),
    .rst          (rst),
    .cmd_req      (cmd_req),
    .cmd_op       (cmd_op),
    .cmd_addr     (cmd_addr),
    .cmd_wdata    (cmd_wdata),
    .cmd_ack      (cmd_ack),
    .mem_allowin  (mem_allowin),
    .ex_mem_valid (ex_mem_valid),
    .ex_op        (ex_op),
    .ex_addr      (ex_addr),
    .ex_wdata     (ex_wdata),
    .rd_en        (rd_en),
    .rd_index     (rd_index)
  );

  // one RAM per byte lane.
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    byte_lane_ram u_ram (
      .clk      (clk),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .wr_en    (byte_enable[i]),
      .wr_index (wr_index),
      .wr_byte  (mem_wr_data[8*i +: 8]),
      .rd_byte  (mem_rd_data[8*i +: 8])
    );
  end

  mem_stage u_mem (
    .clk          (clk),
    .rst          (rst),
    .wb_allowin   (wb_allowin),
    .mem_allowin  (mem_allowin),
    .ex_mem_valid (ex_mem_valid),
    .mem_wb_valid (mem_wb_valid),
    .ex_op        (ex_op),
    .ex_addr      (ex_addr),
    .ex_wdata     (ex_wdata),
    .mem_rd_data  (mem_rd_data),
    .mem_data     (mem_data),
    .mem_excp     (mem_excp),
    .mem_wr_data  (mem_wr_data),
    .byte_enable  (byte_enable),
    .wr_index     (wr_index)
  );

  wb_stage u_wb (
    .clk          (clk),
    .rst          (rst),
    .mem_wb_valid (mem_wb_valid),
    .mem_data     (mem_data),
    .mem_excp     (mem_excp),
    .wb_allowin   (wb_allowin),
    .rsp_req      (rsp_req),
    .rsp_ack      (rsp_ack),
    .rsp_data     (rsp_data),
    .rsp_excp     (rsp_excp)
  );

endmodule

// File: mem_stage.sv
`timescale 1ns/100ps

module mem_stage import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_allowin,
  output logic              mem_allowin,
  input  logic              ex_mem_valid,
  output logic              mem_wb_valid,
  input  mem_op_e           ex_op,
  input  logic [ADDR_W-1:0] ex_addr,
  input  logic [XLEN-1:0]   ex_wdata,
  input  logic [XLEN-1:0]   mem_rd_data,
  output logic [XLEN-1:0]   mem_data,
  output logic              mem_excp,
  output logic [XLEN-1:0]   mem_wr_data,
  output logic [LANES-1:0]  byte_enable,
  output logic [IDX_W-1:0]  wr_index
);

  logic              mem_valid;
  mem_op_e           mem_op;
  logic [ADDR_W-1:0] mem_addr;
  logic [XLEN-1:0]   mem_wdata;
  logic [OFF_W-1:0]  offset;
  logic [XLEN-1:0]   mem_part;
  logic [XLEN-1:0]   load_val;
  logic [LANES-1:0]  lane_mask;
  logic              is_store;
  logic              misaligned;

  // one cycle of work, so only write-back can hold the stage.
  assign mem_allowin  = !mem_valid || wb_allowin;
  assign mem_wb_valid = mem_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_allowin && ex_mem_valid) begin
      mem_op    <= ex_op;
      mem_addr  <= ex_addr;
      mem_wdata <= ex_wdata;
    end
  end

  assign offset   = mem_addr[OFF_W-1:0];
  assign wr_index = mem_addr[ADDR_W-1:OFF_W];

  // size decode for alignment, lane mask and store flag.
  always_comb begin
    misaligned = 1'b0;
    lane_mask  = '0;
    is_store   = 1'b0;
    case (mem_op)
      OP_LH, OP_LHU: misaligned = offset[0];
      OP_LW, OP_LWU: misaligned = |offset[1:0];
      OP_LD:         misaligned = |offset;
      OP_SB: begin
        is_store  = 1'b1;
        lane_mask = LANES'(1) << offset;
      end
      OP_SH: begin
        is_store   = 1'b1;
        misaligned = offset[0];
        lane_mask  = LANES'(3) << offset;
      end
      OP_SW: begin
        is_store   = 1'b1;
        misaligned = |offset[1:0];
        lane_mask  = LANES'(15) << offset;
      end
      OP_SD: begin
        is_store   = 1'b1;
        misaligned = |offset;
        lane_mask  = '1;
      end
      default: ;
    endcase
  end

  assign mem_excp = misaligned;

  // write only as the store leaves for write-back.
  assign byte_enable = (mem_wb_valid && wb_allowin && is_store && !misaligned) ?
                       lane_mask : '0;
  assign mem_wr_data = mem_wdata << {offset, 3'b000};

  assign mem_part = mem_rd_data >> {offset, 3'b000};

  always_comb begin
    case (mem_op)
      OP_LB:   load_val = {{(XLEN-8){mem_part[7]}}, mem_part[7:0]};
      OP_LH:   load_val = {{(XLEN-16){mem_part[15]}}, mem_part[15:0]};
      OP_LW:   load_val = {{(XLEN-32){mem_part[31]}}, mem_part[31:0]};
      OP_LD:   load_val = mem_part;
      OP_LBU:  load_val = {{(XLEN-8){1'b0}}, mem_part[7:0]};
      OP_LHU:  load_val = {{(XLEN-16){1'b0}}, mem_part[15:0]};
      OP_LWU:  load_val = {{(XLEN-32){1'b0}}, mem_part[31:0]};
      default: load_val = '0;
    endcase
  end

  // stores and faulting loads return zero.
  assign mem_data = misaligned ? '0 : load_val;

  be_needs_valid: assert property (@(posedge clk) disable iff (rst)
    !mem_valid |-> byte_enable == '0);

  be_blocked_on_excp: assert property (@(posedge clk) disable iff (rst)
    mem_excp |-> byte_enable == '0);

endmodule

// File: tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu import lsu_pkg::*; ();

  localparam int N_RANDOM   = 400;
  localparam int WAIT_LIMIT = 200;

  logic              clk;
  logic              rst;
  logic              cmd_req;
  logic              cmd_ack;
  mem_op_e           cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [XLEN-1:0]   cmd_wdata;
  logic              rsp_req;
  logic              rsp_ack;
  logic [XLEN-1:0]   rsp_data;
  logic              rsp_excp;
  int                errors;
  int                pending;
  int                responses;
  int                timeouts;
  int                rsp_timeouts;
  int                sent;
  logic [31:0]       cmd_seed;
  logic [31:0]       rsp_seed;

  lsu_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack),
    .rsp_data  (rsp_data),
    .rsp_excp  (rsp_excp)
  );

  lsu_checker chk0 (
    .clk       (clk),
    .rst       (rst),
    .cmd_ack   (cmd_ack),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .rsp_req   (rsp_req),
    .rsp_data  (rsp_data),
    .rsp_excp  (rsp_excp),
    .errors    (errors),
    .pending   (pending),
    .responses (responses)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] rand16();
    cmd_seed = lcg_step(cmd_seed);
    return cmd_seed[31:16];
  endfunction

  function automatic logic [XLEN-1:0] rand_data();
    logic [XLEN-1:0] d;
    d = '0;
    for (int i = 0; i < 4; i++) begin
      d = (d << 16) | XLEN'(rand16());
    end
    return d;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 1;
      OP_LH, OP_LHU, OP_SH: return 2;
      OP_LW, OP_LWU, OP_SW: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] byte_addr(input int idx, input int off);
    return {IDX_W'(idx), OFF_W'(off)};
  endfunction

  // one full four-phase exchange; skipped once anything has timed out.
  task automatic send_cmd(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [XLEN-1:0] wdata);
    int n;
    if (timeouts == 0) begin
      @(posedge clk);
      cmd_req   <= 1'b1;
      cmd_op    <= op;
      cmd_addr  <= addr;
      cmd_wdata <= wdata;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!cmd_ack && n < WAIT_LIMIT);
      cmd_req <= 1'b0;
      if (!cmd_ack) begin
        timeouts++;
        $display("cmd_ack did not rise for command %0d", sent);
      end else begin
        n = 0;
        do begin
          @(posedge clk);
          n++;
        end while (cmd_ack && n < WAIT_LIMIT);
        if (cmd_ack) begin
          timeouts++;
          $display("cmd_ack did not fall for command %0d", sent);
        end
      end
      sent++;
    end
  endtask

  initial begin : responder
    int n;
    int delay;
    rsp_seed = 32'd59;
    rsp_ack  = 1'b0;
    repeat (5) @(posedge clk);
    forever begin
      n = 0;
      while (!rsp_req && n < WAIT_LIMIT) begin
        @(posedge clk);
        n++;
      end
      if (!rsp_req) begin
        rsp_timeouts++;
        $display("no rsp_req within %0d cycles", WAIT_LIMIT);
      end else begin
        rsp_seed = lcg_step(rsp_seed);
        delay    = int'(rsp_seed[31:30]);
        repeat (delay) @(posedge clk);
        rsp_ack <= 1'b1;
        n = 0;
        do begin
          @(posedge clk);
          n++;
        end while (rsp_req && n < WAIT_LIMIT);
        if (rsp_req) begin
          rsp_timeouts++;
          $display("rsp_req did not fall after rsp_ack");
        end
        rsp_ack <= 1'b0;
        @(posedge clk);
      end
    end
  end

  initial begin : stimulus
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    int                n;
    cmd_seed  = 32'd59;
    rst       = 1'b1;
    cmd_req   = 1'b0;
    cmd_op    = OP_LD;
    cmd_addr  = '0;
    cmd_wdata = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // fill every word, then read each back.
    for (int i = 0; i < DEPTH; i++) begin
      send_cmd(OP_SD, byte_addr(i, 0), rand_data());
    end
    for (int i = 0; i < DEPTH; i++) begin
      send_cmd(OP_LD, byte_addr(i, 0), '0);
    end

    send_cmd(OP_SB, byte_addr(2, 5), rand_data());
    send_cmd(OP_SH, byte_addr(3, 2), rand_data());
    send_cmd(OP_SW, byte_addr(4, 4), rand_data());
    for (int i = 2; i < 5; i++) begin
      send_cmd(OP_LD, byte_addr(i, 0), '0);
    end

    // mixed sign bits across the lanes.
    send_cmd(OP_SD, byte_addr(5, 0), 64'h8081_7f80_ff01_7e90);
    for (int b = 0; b < LANES; b++) begin
      send_cmd(OP_LB, byte_addr(5, b), '0);
      send_cmd(OP_LBU, byte_addr(5, b), '0);
      if (b % 2 == 0) begin
        send_cmd(OP_LH, byte_addr(5, b), '0);
        send_cmd(OP_LHU, byte_addr(5, b), '0);
      end
      if (b % 4 == 0) begin
        send_cmd(OP_LW, byte_addr(5, b), '0);
        send_cmd(OP_LWU, byte_addr(5, b), '0);
      end
    end

    // misaligned loads and stores.
    send_cmd(OP_LH, byte_addr(6, 1), '0);
    send_cmd(OP_LW, byte_addr(6, 2), '0);
    send_cmd(OP_LD, byte_addr(6, 4), '0);
    send_cmd(OP_SH, byte_addr(6, 3), rand_data());
    send_cmd(OP_SW, byte_addr(6, 6), rand_data());
    send_cmd(OP_SD, byte_addr(6, 1), rand_data());
    send_cmd(OP_LD, byte_addr(6, 0), '0);

    for (int k = 0; k < N_RANDOM; k++) begin
      op   = mem_op_e'(4'(rand16() % 16'd11));
      addr = ADDR_W'(rand16());
      // three in four aligned.
      if (rand16() % 16'd4 != 0) begin
        addr[OFF_W-1:0] = addr[OFF_W-1:0] & ~OFF_W'(access_bytes(op) - 1);
      end
      send_cmd(op, addr, rand_data());
    end

    n = 0;
    while (pending != 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("%0d command(s) never got a response", pending);
    end
    repeat (2) @(posedge clk);

    $display("commands %0d, responses %0d, mismatches %0d, timeouts %0d",
             sent, responses, errors, timeouts + rsp_timeouts);
    if (errors == 0 && timeouts + rsp_timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: wb_stage.sv
`timescale 1ns/100ps

module wb_stage import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            mem_wb_valid,
  input  logic [XLEN-1:0] mem_data,
  input  logic            mem_excp,
  output logic            wb_allowin,
  output logic            rsp_req,
  input  logic            rsp_ack,
  output logic [XLEN-1:0] rsp_data,
  output logic            rsp_excp
);

  hs_state_e state;
  logic      accept;

  // free once the previous exchange has fully closed.
  assign wb_allowin = (state == HS_IDLE) || (state == HS_DONE && !rsp_ack);
  assign accept     = wb_allowin && mem_wb_valid;
  assign rsp_req    = (state == HS_BUSY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HS_IDLE;
    end else begin
      case (state)
        HS_IDLE: begin
          if (accept) begin
            state <= HS_BUSY;
          end
        end
        HS_BUSY: begin
          if (rsp_ack) begin
            state <= HS_DONE;
          end
        end
        HS_DONE: begin
          if (accept) begin
            state <= HS_BUSY;
          end else if (!rsp_ack) begin
            state <= HS_IDLE;
          end
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data <= mem_data;
      rsp_excp <= mem_excp;
    end
  end

  // response fields hold for the whole request phase.
  rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_req && $past(rsp_req) |-> $stable(rsp_data) && $stable(rsp_excp));

endmodule
